// File: source/motion_pkg.sv
`default_nettype none

package motion_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // frame geometry and marker colour thresholds

    localparam int FRAME_WIDTH  = 320;
    localparam int FRAME_HEIGHT = 240;

    // player 1 is a strong red marker
    localparam int P1_RED_MIN = 11;
    localparam int P1_GB_MAX  = 2;

    // player 2 is a bright white marker
    localparam int P2_WHITE_MIN = 13;

    ////////////////////////////////////////////////////////////////////////////
    // divider and motion window

    // quotient width, also the number of run cycles
    localparam int DIV_CYCLES = 24;
    localparam int DIV_CNT_W  = $clog2(DIV_CYCLES);

    localparam int WINDOW_UPDATES = 8;
    localparam int WIN_CNT_W      = $clog2(WINDOW_UPDATES);

    // gesture thresholds on the window magnitudes
    localparam int PUNCH_DX_MIN = 'h40;
    localparam int PUNCH_DY_MAX = 'h30;
    localparam int KICK_DY_MIN  = 'h40;
    localparam int KICK_DX_MAX  = 'h30;

    ////////////////////////////////////////////////////////////////////////////
    // types

    typedef logic [8:0]  x_coord_t;
    typedef logic [7:0]  y_coord_t;
    typedef logic [11:0] rgb444_t;
    typedef logic [15:0] pixel_count_t;
    typedef logic [23:0] coord_sum_t;
    typedef logic [8:0]  step_mag_t;
    typedef logic [12:0] window_mag_t;

    typedef struct packed {
        logic     valid;
        x_coord_t column;
        y_coord_t row;
        rgb444_t  rgb;
    } cam_pixel_t;

    typedef struct packed {
        pixel_count_t count;
        coord_sum_t   x_sum;
        coord_sum_t   y_sum;
    } blob_sums_t;

    typedef struct packed {
        logic     seen;
        x_coord_t x;
        y_coord_t y;
    } centroid_t;

    // sign-magnitude, negative set when the value decreased
    typedef struct packed {
        logic        negative;
        window_mag_t mag;
    } motion_axis_t;

    typedef struct packed {
        motion_axis_t dx;
        motion_axis_t dy;
    } player_motion_t;

    typedef struct packed {
        logic punch;
        logic kick;
    } gesture_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_t;

endpackage

`default_nettype wire

// File: source/blob_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module blob_accumulator import motion_pkg::*; (
    input  wire logic       clk_65mhz,
    input  wire logic       reset_8frame_delta_values,
    input  wire cam_pixel_t pixel,
    input  wire logic       frame_end,
    output logic            blob_valid,
    output blob_sums_t      p1_blob,
    output blob_sums_t      p2_blob
);

    x_coord_t   mirror_x;
    logic       is_p1;
    logic       is_p2;
    blob_sums_t acc_p1;
    blob_sums_t acc_p2;

    function automatic blob_sums_t add_pixel(input blob_sums_t s, input x_coord_t x,
                                             input y_coord_t y);
        blob_sums_t r;
        r       = s;
        r.count = s.count + 1'b1;
        r.x_sum = s.x_sum + coord_sum_t'(x);
        r.y_sum = s.y_sum + coord_sum_t'(y);
        return r;
    endfunction

    // camera image is shown mirrored
    assign mirror_x = x_coord_t'(FRAME_WIDTH - 1) - pixel.column;

    // red marker takes priority over white
    assign is_p1 = pixel.valid && (pixel.rgb[11:8] > P1_RED_MIN) &&
                   (pixel.rgb[7:4] < P1_GB_MAX) && (pixel.rgb[3:0] < P1_GB_MAX);
    assign is_p2 = pixel.valid && !is_p1 && (pixel.rgb[11:8] > P2_WHITE_MIN) &&
                   (pixel.rgb[7:4] > P2_WHITE_MIN) && (pixel.rgb[3:0] > P2_WHITE_MIN);

    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            blob_valid <= 1'b0;
            acc_p1     <= '0;
            acc_p2     <= '0;
        end else begin
            blob_valid <= frame_end;
            if (frame_end) begin
                // hand the frame totals to the dividers and start over
                p1_blob <= acc_p1;
                p2_blob <= acc_p2;
                acc_p1  <= '0;
                acc_p2  <= '0;
            end else if (is_p1) begin
                acc_p1 <= add_pixel(acc_p1, mirror_x, pixel.row);
            end else if (is_p2) begin
                acc_p2 <= add_pixel(acc_p2, mirror_x, pixel.row);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // camera stream checks

    a_pixel_in_frame: assert property (@(posedge clk_65mhz)
        disable iff (reset_8frame_delta_values)
        pixel.valid |-> (pixel.column < FRAME_WIDTH) && (pixel.row < FRAME_HEIGHT));

    // totals would lose this pixel otherwise
    a_no_pixel_at_frame_end: assert property (@(posedge clk_65mhz)
        disable iff (reset_8frame_delta_values)
        !(pixel.valid && frame_end));

endmodule

`default_nettype wire

// File: source/centroid_divider.sv
`timescale 1ns/1ps
`default_nettype none

module centroid_divider import motion_pkg::*; (
    input  wire logic       clk_65mhz,
    input  wire logic       reset_8frame_delta_values,
    input  wire logic       start,
    input  wire blob_sums_t blob,
    output logic            centroid_valid,
    output centroid_t       centroid
);

    div_state_t             state;
    logic [DIV_CNT_W-1:0]   bit_cnt;
    pixel_count_t           divisor;
    logic                   seen;
    pixel_count_t           x_rem;
    pixel_count_t           y_rem;
    coord_sum_t             x_quo;
    coord_sum_t             y_quo;

    // one restoring step, returns {remainder, quotient}
    function automatic logic [39:0] div_step(input pixel_count_t rem, input coord_sum_t quo,
                                             input pixel_count_t den);
        logic [16:0] trial;
        trial = {rem, quo[23]};
        if (trial >= {1'b0, den}) begin
            trial    = trial - {1'b0, den};
            div_step = {trial[15:0], quo[22:0], 1'b1};
        end else begin
            div_step = {trial[15:0], quo[22:0], 1'b0};
        end
    endfunction

    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            state   <= DIV_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (start) begin
                        // quotient register starts out holding the dividend
                        x_rem   <= '0;
                        y_rem   <= '0;
                        x_quo   <= blob.x_sum;
                        y_quo   <= blob.y_sum;
                        divisor <= blob.count;
                        seen    <= (blob.count != '0);
                        bit_cnt <= '0;
                        state   <= DIV_RUN;
                    end
                end
                DIV_RUN: begin
                    {x_rem, x_quo} <= div_step(x_rem, x_quo, divisor);
                    {y_rem, y_quo} <= div_step(y_rem, y_quo, divisor);
                    bit_cnt        <= bit_cnt + 1'b1;
                    if (bit_cnt == DIV_CNT_W'(DIV_CYCLES - 1)) begin
                        state <= DIV_DONE;
                    end
                end
                default: begin
                    state <= DIV_IDLE;
                end
            endcase
        end
    end

    // mean of in-frame coordinates always fits the coordinate width
    assign centroid_valid = (state == DIV_DONE);
    assign centroid       = '{seen: seen, x: x_coord_t'(x_quo), y: y_coord_t'(y_quo)};

    a_start_when_idle: assert property (@(posedge clk_65mhz)
        disable iff (reset_8frame_delta_values)
        start |-> state == DIV_IDLE);

endmodule

`default_nettype wire

// File: source/motion_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module motion_accumulator import motion_pkg::*; (
    input  wire logic      clk_65mhz,
    input  wire logic      reset_8frame_delta_values,
    input  wire logic      centroid_valid,
    input  wire centroid_t p1_centroid,
    input  wire centroid_t p2_centroid,
    output logic           window_valid,
    output player_motion_t p1_motion,
    output player_motion_t p2_motion
);

    centroid_t            cen          [2];
    x_coord_t             last_x       [2];
    y_coord_t             last_y       [2];
    logic                 has_position [2];
    player_motion_t       total        [2];
    player_motion_t       next_total   [2];
    logic [WIN_CNT_W-1:0] upd_cnt;
    logic                 window_end;

    // one-update step is zero without a valid previous sighting
    function automatic motion_axis_t axis_step(input step_mag_t new_pos, input step_mag_t old_pos,
                                               input logic enable);
        motion_axis_t s;
        s = '0;
        if (enable) begin
            s.negative = (new_pos < old_pos);
            s.mag      = s.negative ? window_mag_t'(old_pos - new_pos)
                                    : window_mag_t'(new_pos - old_pos);
        end
        return s;
    endfunction

    // sign-magnitude add of a step into a running total
    function automatic motion_axis_t fold(input motion_axis_t tot, input motion_axis_t st);
        motion_axis_t r;
        if (tot.negative == st.negative) begin
            r = '{negative: tot.negative, mag: tot.mag + st.mag};
        end else if (tot.mag > st.mag) begin
            r = '{negative: tot.negative, mag: tot.mag - st.mag};
        end else begin
            // equal magnitudes land here and give zero with the step sign
            r = '{negative: st.negative, mag: st.mag - tot.mag};
        end
        return r;
    endfunction

    assign cen[0]     = p1_centroid;
    assign cen[1]     = p2_centroid;
    assign window_end = (upd_cnt == WIN_CNT_W'(WINDOW_UPDATES - 1));

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            next_total[p].dx = fold(total[p].dx, axis_step(step_mag_t'(cen[p].x),
                step_mag_t'(last_x[p]), cen[p].seen && has_position[p]));
            next_total[p].dy = fold(total[p].dy, axis_step(step_mag_t'(cen[p].y),
                step_mag_t'(last_y[p]), cen[p].seen && has_position[p]));
        end
    end

    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            upd_cnt      <= '0;
            window_valid <= 1'b0;
            p1_motion    <= '0;
            p2_motion    <= '0;
            for (int p = 0; p < 2; p++) begin
                total[p]        <= '0;
                has_position[p] <= 1'b0;
            end
        end else begin
            window_valid <= 1'b0;
            if (centroid_valid) begin
                // an absent player keeps its last known position
                for (int p = 0; p < 2; p++) begin
                    if (cen[p].seen) begin
                        last_x[p]       <= cen[p].x;
                        last_y[p]       <= cen[p].y;
                        has_position[p] <= 1'b1;
                    end
                end
                if (window_end) begin
                    window_valid <= 1'b1;
                    upd_cnt      <= '0;
                    p1_motion    <= next_total[0];
                    p2_motion    <= next_total[1];
                    total[0]     <= '0;
                    total[1]     <= '0;
                end else begin
                    upd_cnt  <= upd_cnt + 1'b1;
                    total[0] <= next_total[0];
                    total[1] <= next_total[1];
                end
            end
        end
    end

    // a held valid would be counted as several updates
    a_valid_is_pulse: assert property (@(posedge clk_65mhz)
        disable iff (reset_8frame_delta_values)
        centroid_valid |=> !centroid_valid);

endmodule

`default_nettype wire

// File: source/gesture_classifier.sv
`timescale 1ns/1ps
`default_nettype none

module gesture_classifier import motion_pkg::*; (
    input  wire logic           clk_65mhz,
    input  wire logic           reset_8frame_delta_values,
    input  wire logic           window_valid,
    input  wire player_motion_t p1_motion,
    input  wire player_motion_t p2_motion,
    output logic                gesture_valid,
    output gesture_t            p1_gesture,
    output gesture_t            p2_gesture,
    output player_motion_t      p1_motion_out,
    output player_motion_t      p2_motion_out
);

    // thresholds look at magnitude only, direction is ignored
    function automatic gesture_t classify(input player_motion_t m);
        gesture_t g;
        g.punch = (m.dx.mag > PUNCH_DX_MIN) && (m.dy.mag < PUNCH_DY_MAX);
        g.kick  = (m.dy.mag > KICK_DY_MIN) && (m.dx.mag < KICK_DX_MAX);
        return g;
    endfunction

    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            gesture_valid <= 1'b0;
            p1_gesture    <= '0;
            p2_gesture    <= '0;
            p1_motion_out <= '0;
            p2_motion_out <= '0;
        end else begin
            gesture_valid <= window_valid;
            // held until the next window closes
            if (window_valid) begin
                p1_gesture    <= classify(p1_motion);
                p2_gesture    <= classify(p2_motion);
                p1_motion_out <= p1_motion;
                p2_motion_out <= p2_motion;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/motion_tracker_top.sv
`timescale 1ns/1ps
`default_nettype none

module motion_tracker_top import motion_pkg::*; (
    input  wire logic       clk_65mhz,
    input  wire logic       reset_8frame_delta_values,
    input  wire cam_pixel_t pixel,
    input  wire logic       frame_end,
    output logic            gesture_valid,
    output gesture_t        p1_gesture,
    output gesture_t        p2_gesture,
    output player_motion_t  p1_motion,
    output player_motion_t  p2_motion
);

    logic           blob_valid;
    blob_sums_t     p1_blob;
    blob_sums_t     p2_blob;
    logic           centroid_valid;
    centroid_t      p1_centroid;
    centroid_t      p2_centroid;
    logic           window_valid;
    player_motion_t p1_window;
    player_motion_t p2_window;

    ////////////////////////////////////////////////////////////////////////////
    // pixel sums, one divider per player

    blob_accumulator blob_acc (
        .clk_65mhz                 (clk_65mhz),
        .reset_8frame_delta_values (reset_8frame_delta_values),
        .pixel                     (pixel),
        .frame_end                 (frame_end),
        .blob_valid                (blob_valid),
        .p1_blob                   (p1_blob),
        .p2_blob                   (p2_blob)
    );

    centroid_divider p1_div (
        .clk_65mhz                 (clk_65mhz),
        .reset_8frame_delta_values (reset_8frame_delta_values),
        .start                     (blob_valid),
        .blob                      (p1_blob),
        .centroid_valid            (centroid_valid),
        .centroid                  (p1_centroid)
    );

    // both dividers start together with fixed latency, so one valid serves both
    centroid_divider p2_div (
        .clk_65mhz                 (clk_65mhz),
        .reset_8frame_delta_values (reset_8frame_delta_values),
        .start                     (blob_valid),
        .blob                      (p2_blob),
        .centroid_valid            (),
        .centroid                  (p2_centroid)
    );

    ////////////////////////////////////////////////////////////////////////////
    // motion window and gestures

    motion_accumulator motion_acc (
        .clk_65mhz                 (clk_65mhz),
        .reset_8frame_delta_values (reset_8frame_delta_values),
        .centroid_valid            (centroid_valid),
        .p1_centroid               (p1_centroid),
        .p2_centroid               (p2_centroid),
        .window_valid              (window_valid),
        .p1_motion                 (p1_window),
        .p2_motion                 (p2_window)
    );

    gesture_classifier gesture_cls (
        .clk_65mhz                 (clk_65mhz),
        .reset_8frame_delta_values (reset_8frame_delta_values),
        .window_valid              (window_valid),
        .p1_motion                 (p1_window),
        .p2_motion                 (p2_window),
        .gesture_valid             (gesture_valid),
        .p1_gesture                (p1_gesture),
        .p2_gesture                (p2_gesture),
        .p1_motion_out             (p1_motion),
        .p2_motion_out             (p2_motion)
    );

endmodule

`default_nettype wire

// File: sim/tb_frame_tasks.svh
`ifndef TB_FRAME_TASKS_SVH
`define TB_FRAME_TASKS_SVH

    // lcg draw in the range 0 to span-1
    function automatic int next_random(input int span);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[30:8]) % span;
    endfunction

    function automatic void pick_blob_size();
        blob_w = 2 + next_random(4);
        blob_h = 2 + next_random(4);
    endfunction

    // centre path for the back and forth test
    function automatic int back_forth_x(input int f);
        int xs [8] = '{100, 125, 105, 140, 110, 135, 100, 120};
        return xs[f];
    endfunction

    function automatic int back_forth_y(input int f);
        int ys [8] = '{80, 85, 80, 90, 80, 85, 80, 84};
        return ys[f];
    endfunction

    task automatic drive_pixel(input int col, input int row, input rgb444_t colour);
        @(posedge clk_65mhz);
        pixel <= '{valid: 1'b1, column: x_coord_t'(col), row: y_coord_t'(row), rgb: colour};
    endtask

    // rectangle of marker pixels, also added to the model sums
    task automatic send_blob(input int player, input int cx, input int cy);
        rgb444_t colour;
        for (int r = 0; r < blob_h; r++) begin
            for (int c = 0; c < blob_w; c++) begin
                if (player == 0) begin
                    colour = {4'(12 + next_random(4)), 4'(next_random(2)), 4'(next_random(2))};
                end else begin
                    colour = {4'(14 + next_random(2)), 4'(14 + next_random(2)),
                              4'(14 + next_random(2))};
                end
                drive_pixel(cx + c, cy + r, colour);
                model_count[player]++;
                model_xsum[player] += FRAME_WIDTH - 1 - (cx + c);
                model_ysum[player] += cy + r;
            end
        end
    endtask

    task automatic send_filler(input int n);
        rgb444_t colour;
        int      col;
        int      row;
        for (int i = 0; i < n; i++) begin
            // green of 2 to 13 fails both marker rules
            colour = {4'(next_random(16)), 4'(2 + next_random(12)), 4'(next_random(16))};
            col    = next_random(FRAME_WIDTH);
            row    = next_random(FRAME_HEIGHT);
            drive_pixel(col, row, colour);
        end
    endtask

    task automatic close_frame();
        @(posedge clk_65mhz);
        pixel     <= '0;
        frame_end <= 1'b1;
        @(posedge clk_65mhz);
        frame_end <= 1'b0;
        model_frame_end();
        repeat (40) @(posedge clk_65mhz);
    endtask

    task automatic send_frame(input logic p1_on, input int p1_x, input int p1_y,
                              input logic p2_on, input int p2_x, input int p2_y,
                              input int filler);
        if (p1_on) begin
            send_blob(0, p1_x, p1_y);
        end
        if (p2_on) begin
            send_blob(1, p2_x, p2_y);
        end
        send_filler(filler);
        close_frame();
    endtask

    task automatic apply_reset();
        @(posedge clk_65mhz);
        reset_8frame_delta_values <= 1'b1;
        pixel                     <= '0;
        frame_end                 <= 1'b0;
        repeat (10) @(posedge clk_65mhz);
        reset_8frame_delta_values <= 1'b0;
        model_reset();
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got == expected) else begin
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, expected);
            errors++;
        end
    endtask

    // window count seen at the pins, bounded by 2000 cycles
    task automatic wait_windows(input int target);
        int cycles;
        cycles = 0;
        while (windows_seen < target && cycles < 2000) begin
            @(posedge clk_65mhz);
            cycles++;
        end
        if (windows_seen < target) begin
            $display("timeout at %0t: gesture_valid did not arrive within 2000 cycles", $time);
            errors++;
        end else begin
            check_field("windows_seen", windows_seen, target);
        end
    endtask

    task automatic report_test(input int num, input string what, input int errors_before);
        if (errors == errors_before) begin
            $display("test %0d %s: ok", num, what);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", num, what, errors - errors_before);
        end
    endtask

`endif

// File: sim/tb_motion_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_motion_tracker import motion_pkg::*; ();

    logic           clk_65mhz;
    logic           reset_8frame_delta_values;
    cam_pixel_t     pixel;
    logic           frame_end;
    logic           gesture_valid;
    gesture_t       p1_gesture;
    gesture_t       p2_gesture;
    player_motion_t p1_motion;
    player_motion_t p2_motion;

    // stimulus and scoreboard state
    logic [31:0]    lcg_state;
    int             blob_w;
    int             blob_h;
    int             errors;
    int             tests_failed;
    int             frame_ends_seen;
    int             windows_seen;
    logic           window_closing;

    // reference model state
    int             model_count   [2];
    int             model_xsum    [2];
    int             model_ysum    [2];
    int             model_last_x  [2];
    int             model_last_y  [2];
    logic           model_has_pos [2];
    player_motion_t model_total   [2];
    int             model_updates;
    player_motion_t exp_motion    [2];
    gesture_t       exp_gesture   [2];

    motion_tracker_top dut0 (
        .clk_65mhz                 (clk_65mhz),
        .reset_8frame_delta_values (reset_8frame_delta_values),
        .pixel                     (pixel),
        .frame_end                 (frame_end),
        .gesture_valid             (gesture_valid),
        .p1_gesture                (p1_gesture),
        .p2_gesture                (p2_gesture),
        .p1_motion                 (p1_motion),
        .p2_motion                 (p2_motion)
    );

    initial begin
        clk_65mhz = 1'b0;
        forever begin
            #50 clk_65mhz = ~clk_65mhz;
        end
    end

    // frame and window counters seen at the DUT pins
    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            frame_ends_seen <= 0;
            windows_seen    <= 0;
        end else begin
            if (frame_end) begin
                frame_ends_seen <= frame_ends_seen + 1;
            end
            if (gesture_valid) begin
                windows_seen <= windows_seen + 1;
            end
        end
    end

    assign window_closing = frame_end &&
        (frame_ends_seen % WINDOW_UPDATES == WINDOW_UPDATES - 1);

    ////////////////////////////////////////////////////////////////////////////
    // model versus DUT at each window

    a_p1_motion: assert property (@(posedge clk_65mhz) disable iff (reset_8frame_delta_values)
        gesture_valid |-> p1_motion == exp_motion[0])
        else begin
            $display("mismatch at %0t: p1_motion got %h expected %h", $time,
                $sampled(p1_motion), $sampled(exp_motion[0]));
            errors++;
        end

    a_p2_motion: assert property (@(posedge clk_65mhz) disable iff (reset_8frame_delta_values)
        gesture_valid |-> p2_motion == exp_motion[1])
        else begin
            $display("mismatch at %0t: p2_motion got %h expected %h", $time,
                $sampled(p2_motion), $sampled(exp_motion[1]));
            errors++;
        end

    a_p1_gesture: assert property (@(posedge clk_65mhz) disable iff (reset_8frame_delta_values)
        gesture_valid |-> p1_gesture == exp_gesture[0])
        else begin
            $display("mismatch at %0t: p1_gesture got %b expected %b", $time,
                $sampled(p1_gesture), $sampled(exp_gesture[0]));
            errors++;
        end

    a_p2_gesture: assert property (@(posedge clk_65mhz) disable iff (reset_8frame_delta_values)
        gesture_valid |-> p2_gesture == exp_gesture[1])
        else begin
            $display("mismatch at %0t: p2_gesture got %b expected %b", $time,
                $sampled(p2_gesture), $sampled(exp_gesture[1]));
            errors++;
        end

    // eighth frame_end to gesture_valid and back
    a_window_latency: assert property (@(posedge clk_65mhz)
        disable iff (reset_8frame_delta_values)
        $past(window_closing, DIV_CYCLES + 4) |-> $rose(gesture_valid))
        else begin
            $display("gesture_valid did not follow the eighth frame_end in time at %0t", $time);
            errors++;
        end

    a_no_stray_window: assert property (@(posedge clk_65mhz)
        disable iff (reset_8frame_delta_values)
        $rose(gesture_valid) |-> $past(window_closing, DIV_CYCLES + 4))
        else begin
            $display("gesture_valid rose without an eighth frame_end before it at %0t", $time);
            errors++;
        end

    ////////////////////////////////////////////////////////////////////////////
    // reference model

    function automatic motion_axis_t model_step(input int new_pos, input int old_pos,
                                                input logic enable);
        motion_axis_t s;
        s = '0;
        if (enable && new_pos < old_pos) begin
            s.negative = 1'b1;
            s.mag      = window_mag_t'(old_pos - new_pos);
        end else if (enable) begin
            s.mag = window_mag_t'(new_pos - old_pos);
        end
        return s;
    endfunction

    function automatic motion_axis_t model_fold(input motion_axis_t tot, input motion_axis_t st);
        motion_axis_t r;
        if (tot.negative == st.negative) begin
            r.negative = tot.negative;
            r.mag      = tot.mag + st.mag;
        end else if (st.mag >= tot.mag) begin
            r.negative = st.negative;
            r.mag      = st.mag - tot.mag;
        end else begin
            r.negative = tot.negative;
            r.mag      = tot.mag - st.mag;
        end
        return r;
    endfunction

    function automatic gesture_t model_gesture(input player_motion_t m);
        gesture_t g;
        g.punch = (int'(m.dx.mag) > PUNCH_DX_MIN) && (int'(m.dy.mag) < PUNCH_DY_MAX);
        g.kick  = (int'(m.dy.mag) > KICK_DY_MIN) && (int'(m.dx.mag) < KICK_DX_MAX);
        return g;
    endfunction

    function automatic void model_reset();
        for (int p = 0; p < 2; p++) begin
            model_count[p]   = 0;
            model_xsum[p]    = 0;
            model_ysum[p]    = 0;
            model_last_x[p]  = 0;
            model_last_y[p]  = 0;
            model_has_pos[p] = 1'b0;
            model_total[p]   = '0;
            exp_motion[p]    = '0;
            exp_gesture[p]   = '0;
        end
        model_updates = 0;
    endfunction

    function automatic void model_frame_end();
        int   cx;
        int   cy;
        logic moved;
        for (int p = 0; p < 2; p++) begin
            cx    = 0;
            cy    = 0;
            moved = (model_count[p] != 0) && model_has_pos[p];
            if (model_count[p] != 0) begin
                cx = model_xsum[p] / model_count[p];
                cy = model_ysum[p] / model_count[p];
            end
            model_total[p].dx = model_fold(model_total[p].dx,
                model_step(cx, model_last_x[p], moved));
            model_total[p].dy = model_fold(model_total[p].dy,
                model_step(cy, model_last_y[p], moved));
            if (model_count[p] != 0) begin
                model_last_x[p]  = cx;
                model_last_y[p]  = cy;
                model_has_pos[p] = 1'b1;
            end
            model_count[p] = 0;
            model_xsum[p]  = 0;
            model_ysum[p]  = 0;
        end
        model_updates++;
        if (model_updates == WINDOW_UPDATES) begin
            for (int p = 0; p < 2; p++) begin
                exp_motion[p]  = model_total[p];
                exp_gesture[p] = model_gesture(model_total[p]);
                model_total[p] = '0;
            end
            model_updates = 0;
        end
    endfunction

    `include "tb_frame_tasks.svh"

    ////////////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        int first;
        reset_8frame_delta_values = 1'b1;
        pixel                     = '0;
        frame_end                 = 1'b0;
        lcg_state                 = 32'h02f69d98;
        errors                    = 0;
        tests_failed              = 0;
        blob_w                    = 2;
        blob_h                    = 2;
        model_reset();

        // red marker moving right is mirrored into a leftward punch
        first = errors;
        apply_reset();
        pick_blob_size();
        for (int f = 0; f < 8; f++) begin
            send_frame(1'b1, 60 + 12 * f, 100, 1'b0, 0, 0, 0);
        end
        wait_windows(1);
        check_field("p1_motion.dx.negative", p1_motion.dx.negative, 1);
        check_field("p1_motion.dx.mag", p1_motion.dx.mag, 84);
        check_field("p1_gesture", p1_gesture, 2'b10);
        report_test(1, "p1 punch", first);

        // white marker moving down among filler pixels
        first = errors;
        apply_reset();
        pick_blob_size();
        for (int f = 0; f < 8; f++) begin
            send_frame(1'b0, 0, 0, 1'b1, 200, 40 + 10 * f, 20);
        end
        wait_windows(1);
        check_field("p2_motion.dy.negative", p2_motion.dy.negative, 0);
        check_field("p2_motion.dy.mag", p2_motion.dy.mag, 70);
        check_field("p2_gesture", p2_gesture, 2'b01);
        report_test(2, "p2 kick with filler", first);

        // back and forth while p2 stands still
        first = errors;
        apply_reset();
        pick_blob_size();
        for (int f = 0; f < 8; f++) begin
            send_frame(1'b1, back_forth_x(f), back_forth_y(f), 1'b1, 250, 150, 10);
        end
        wait_windows(1);
        check_field("p1_gesture", p1_gesture, 0);
        check_field("p2_gesture", p2_gesture, 0);
        report_test(3, "back and forth fold", first);

        // p1 never seen and p2 appearing in the fourth frame
        first = errors;
        apply_reset();
        pick_blob_size();
        for (int f = 0; f < 8; f++) begin
            send_frame(1'b0, 0, 0, f >= 3, 100 + 20 * f, 120, 10);
        end
        wait_windows(1);
        check_field("p1_motion", p1_motion, 0);
        check_field("p1_gesture", p1_gesture, 0);
        check_field("p2_motion.dx.mag", p2_motion.dx.mag, 80);
        check_field("p2_gesture", p2_gesture, 2'b10);
        report_test(4, "absent and late players", first);

        // reset state and then one window per eight frames
        first = errors;
        apply_reset();
        @(posedge clk_65mhz);
        check_field("gesture_valid", gesture_valid, 0);
        check_field("p1_gesture", p1_gesture, 0);
        check_field("p2_gesture", p2_gesture, 0);
        check_field("p2_motion", p2_motion, 0);
        pick_blob_size();
        for (int f = 0; f < 16; f++) begin
            send_frame(1'b1, 40 + 10 * f, 60, 1'b1, 250 - 10 * f, 180, 5);
            if (f == 6) begin
                check_field("windows_seen", windows_seen, 0);
            end
            if (f == 7) begin
                wait_windows(1);
            end
        end
        wait_windows(2);
        report_test(5, "window cadence", first);

        $display("tests run 5, failed %0d, errors %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: motion_tracker_top.f
+incdir+sim
source/motion_pkg.sv
source/blob_accumulator.sv
source/centroid_divider.sv
source/motion_accumulator.sv
source/gesture_classifier.sv
source/motion_tracker_top.sv
sim/tb_motion_tracker.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_motion_tracker
FILELIST   := motion_tracker_top.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
